// ==== Bender.yml ====
package:
  name: mips_core

sources:
  - files:
      - src/mipsIsaPkg.sv
      - src/mipsPipePkg.sv
      - src/fetchUnit.sv
      - src/instrQueue.sv
      - src/registerFile.sv
      - src/decodeStage.sv
      - src/executeStage.sv
      - src/memoryStage.sv
      - src/mipsCore.sv
  - target: test
    files:
      - testbench/tbClock.sv
      - testbench/mipsCore_chk.sv
      - testbench/mipsCoreTb.sv

// ==== project.f ====
src/mipsIsaPkg.sv
src/mipsPipePkg.sv
src/fetchUnit.sv
src/instrQueue.sv
src/registerFile.sv
src/decodeStage.sv
src/executeStage.sv
src/memoryStage.sv
src/mipsCore.sv
testbench/tbClock.sv
testbench/mipsCore_chk.sv
testbench/mipsCoreTb.sv

// ==== src/decodeStage.sv ====
module decodeStage (
    input  logic                  clk,
    input  logic                  rstN,
    input  mipsPipePkg::fetchPkt  head,
    input  logic                  headValid,
    output logic                  pop,
    output logic                  redirect,
    output mipsPipePkg::word      redirectPc,
    input  mipsPipePkg::bypassPkt exBypass,
    input  mipsPipePkg::bypassPkt memBypass,
    input  logic                  exIsLoad,
    input  mipsPipePkg::regAddr   exDest,
    input  mipsPipePkg::wbPkt     wb,
    output mipsPipePkg::execPkt   execOut
);
    import mipsIsaPkg::*;
    import mipsPipePkg::*;

    instrWord ins;
    regAddr   rsAddr;
    regAddr   rtAddr;
    regAddr   dest;
    word      rsFile;
    word      rtFile;
    word      rsVal;
    word      rtVal;
    word      immExt;
    word      pcPlus4;
    aluOp     aluCtl;
    logic     useImm;
    logic     zeroExt;
    logic     regWrite;
    logic     memRead;
    logic     memWrite;
    logic     isBeq;
    logic     isBne;
    logic     isJump;
    logic     takeBranch;
    logic     freeze;
    logic     issue;
    execPkt   nextExec;

    // Execute result first, then memory, then the file value
    function automatic word pickOperand(regAddr src, word fileVal, bypassPkt ex, bypassPkt mem);
        if (src == '0) return '0;
        if (ex.valid && ex.dest == src) return ex.data;
        if (mem.valid && mem.dest == src) return mem.data;
        return fileVal;
    endfunction

    assign ins    = head.instr;
    assign rsAddr = ins.rType.rs;
    assign rtAddr = ins.rType.rt;

    registerFile regFile (
        .clk    (clk),
        .rstN   (rstN),
        .rsAddr (rsAddr),
        .rtAddr (rtAddr),
        .rsData (rsFile),
        .rtData (rtFile),
        .wb     (wb)
    );

    assign rsVal = pickOperand(rsAddr, rsFile, exBypass, memBypass);
    assign rtVal = pickOperand(rtAddr, rtFile, exBypass, memBypass);

    // ------------------------------
    // Instruction decode
    // ------------------------------
    always_comb begin
        aluCtl   = aluPassB;
        dest     = ins.iType.rt;
        useImm   = 1'b0;
        zeroExt  = 1'b0;
        regWrite = 1'b0;
        memRead  = 1'b0;
        memWrite = 1'b0;
        isBeq    = 1'b0;
        isBne    = 1'b0;
        isJump   = 1'b0;
        case (ins.rType.opcode)
            opSpecial: begin
                dest     = ins.rType.rd;
                regWrite = 1'b1;
                case (ins.rType.funct)
                    fnAddu:  aluCtl = aluAdd;
                    fnSubu:  aluCtl = aluSub;
                    fnAnd:   aluCtl = aluAnd;
                    fnOr:    aluCtl = aluOr;
                    fnSlt:   aluCtl = aluSlt;
                    fnSll:   aluCtl = aluSll;
                    default: regWrite = 1'b0;
                endcase
            end
            opAddiu: {aluCtl, useImm, regWrite} = {aluAdd, 2'b11};
            opOri:   {aluCtl, useImm, zeroExt, regWrite} = {aluOr, 3'b111};
            opLui:   {aluCtl, useImm, regWrite} = {aluLui, 2'b11};
            opLw:    {aluCtl, useImm, regWrite, memRead} = {aluAdd, 3'b111};
            opSw:    {aluCtl, useImm, memWrite} = {aluAdd, 2'b11};
            opBeq:   isBeq = 1'b1;
            opBne:   isBne = 1'b1;
            opJ:     isJump = 1'b1;
            default: ;
        endcase
    end

    assign immExt = zeroExt ? {16'h0, ins.iType.imm16}
                            : {{16{ins.iType.imm16[15]}}, ins.iType.imm16};
    assign pcPlus4 = head.pc + word'(4);

    // Load in execute feeding this instruction holds it one cycle
    assign freeze = headValid && exIsLoad && exDest != '0
                    && (exDest == rsAddr || exDest == rtAddr);

    assign takeBranch = (isBeq && rsVal == rtVal) || (isBne && rsVal != rtVal);
    assign pop        = headValid && !freeze;
    assign redirect   = pop && (takeBranch || isJump);
    assign redirectPc = isJump ? {pcPlus4[xlen-1:28], ins.jType.target26, 2'b00}
                               : pcPlus4 + {immExt[xlen-3:0], 2'b00};
    assign issue      = pop && !redirect;

    assign nextExec = '{
        valid:     issue,
        aluCtl:    aluCtl,
        opA:       rsVal,
        opB:       useImm ? immExt : rtVal,
        shamt:     ins.rType.shamt,
        storeData: rtVal,
        dest:      dest,
        regWrite:  issue && regWrite,
        memRead:   issue && memRead,
        memWrite:  issue && memWrite
    };

    always_ff @(posedge clk) begin
        if (!rstN) begin
            execOut.valid    <= 1'b0;
            execOut.regWrite <= 1'b0;
            execOut.memRead  <= 1'b0;
            execOut.memWrite <= 1'b0;
        end else begin
            execOut <= nextExec;
        end
    end

endmodule

// ==== src/executeStage.sv ====
module executeStage (
    input  logic                  clk,
    input  logic                  rstN,
    input  mipsPipePkg::execPkt   execIn,
    output mipsPipePkg::bypassPkt exBypass,
    output logic                  exIsLoad,
    output mipsPipePkg::regAddr   exDest,
    output mipsPipePkg::memPkt    memOut
);
    import mipsIsaPkg::*;
    import mipsPipePkg::*;

    word aluResult;

    // ------------------------------
    // ALU
    // ------------------------------
    always_comb begin
        case (execIn.aluCtl)
            aluAdd:  aluResult = execIn.opA + execIn.opB;
            aluSub:  aluResult = execIn.opA - execIn.opB;
            aluAnd:  aluResult = execIn.opA & execIn.opB;
            aluOr:   aluResult = execIn.opA | execIn.opB;
            aluSlt:  aluResult = word'($signed(execIn.opA) < $signed(execIn.opB));
            aluSll:  aluResult = execIn.opB << execIn.shamt;
            aluLui:  aluResult = {execIn.opB[15:0], 16'h0};
            // Pass-b and unused codes
            default: aluResult = execIn.opB;
        endcase
    end

    // Load data is not known yet so loads do not forward from here
    assign exBypass = '{
        valid: execIn.valid && execIn.regWrite && !execIn.memRead,
        dest:  execIn.dest,
        data:  aluResult
    };

    assign exIsLoad = execIn.valid && execIn.memRead;
    assign exDest   = execIn.dest;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            memOut.valid    <= 1'b0;
            memOut.regWrite <= 1'b0;
            memOut.memRead  <= 1'b0;
            memOut.memWrite <= 1'b0;
        end else begin
            memOut <= '{
                valid:     execIn.valid,
                aluResult: aluResult,
                storeData: execIn.storeData,
                dest:      execIn.dest,
                regWrite:  execIn.regWrite,
                memRead:   execIn.memRead,
                memWrite:  execIn.memWrite
            };
        end
    end

endmodule

// ==== src/fetchUnit.sv ====
module fetchUnit (
    input  logic                 clk,
    input  logic                 rstN,
    input  logic                 queueFull,
    input  logic                 redirect,
    input  mipsPipePkg::word     redirectPc,
    output mipsPipePkg::word     instrAddress,
    input  mipsPipePkg::word     instr,
    output mipsPipePkg::fetchPkt fetchOut,
    output logic                 push
);
    import mipsPipePkg::*;

    word pc;

    // Redirect wins over the sequential advance
    always_ff @(posedge clk) begin
        if (!rstN) begin
            pc <= '0;
        end else if (redirect) begin
            pc <= redirectPc;
        end else if (!queueFull) begin
            pc <= pc + word'(4);
        end
    end

    assign instrAddress = pc;

    // Instruction port answers in the same cycle
    assign fetchOut = '{instr: instr, pc: pc};

    // The queue drops this push on its own when a flush lands
    assign push = !queueFull;

endmodule

// ==== src/instrQueue.sv ====
module instrQueue (
    input  logic                 clk,
    input  logic                 rstN,
    input  logic                 push,
    input  mipsPipePkg::fetchPkt pushData,
    input  logic                 pop,
    input  logic                 flush,
    output mipsPipePkg::fetchPkt head,
    output logic                 headValid,
    output logic                 full
);
    import mipsPipePkg::*;

    fetchPkt              entries [queueDepth];
    logic [queuePtrW-1:0] rdPtr;
    logic [queuePtrW-1:0] wrPtr;
    logic [queuePtrW:0]   count;
    logic                 doPush;
    logic                 doPop;

    assign doPush = push && !full;
    assign doPop  = pop && headValid;

    // ------------------------------
    // Pointers and occupancy
    // ------------------------------
    always_ff @(posedge clk) begin
        if (!rstN || flush) begin
            rdPtr <= '0;
            wrPtr <= '0;
            count <= '0;
        end else begin
            if (doPush) begin
                wrPtr <= wrPtr + 1'b1;
            end
            if (doPop) begin
                rdPtr <= rdPtr + 1'b1;
            end
            case ({doPush, doPop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Storage
    always_ff @(posedge clk) begin
        if (doPush) begin
            entries[wrPtr] <= pushData;
        end
    end

    assign head      = entries[rdPtr];
    assign headValid = (count != '0);
    assign full      = (count == (queuePtrW + 1)'(queueDepth));

endmodule

// ==== src/memoryStage.sv ====
module memoryStage (
    input  logic                  clk,
    input  logic                  rstN,
    input  mipsPipePkg::memPkt    memIn,
    output mipsPipePkg::word      dataAddress,
    output logic                  memRead,
    output logic                  memWrite,
    output mipsPipePkg::word      writeData,
    input  mipsPipePkg::word      readData,
    output mipsPipePkg::bypassPkt memBypass,
    output mipsPipePkg::wbPkt     wb
);
    import mipsPipePkg::*;

    // Data port, combinational read in this cycle
    assign dataAddress = memIn.aluResult;
    assign memRead     = memIn.valid && memIn.memRead;
    assign memWrite    = memIn.valid && memIn.memWrite;
    assign writeData   = memIn.storeData;

    // Write-back value, load data already folded in
    assign memBypass = '{
        valid: memIn.valid && memIn.regWrite,
        dest:  memIn.dest,
        data:  memIn.memRead ? readData : memIn.aluResult
    };

    always_ff @(posedge clk) begin
        if (!rstN) begin
            wb.valid <= 1'b0;
        end else begin
            wb <= memBypass;
        end
    end

endmodule

// ==== src/mipsCore.sv ====
module mipsCore (
    input  logic             clk,
    input  logic             rstN,
    output mipsPipePkg::word instrAddress,
    input  mipsPipePkg::word instr,
    output mipsPipePkg::word dataAddress,
    output logic             memRead,
    output logic             memWrite,
    output mipsPipePkg::word writeData,
    input  mipsPipePkg::word readData
);
    import mipsPipePkg::*;

    // ------------------------------
    // Front end
    // ------------------------------
    fetchPkt  fetchData;
    fetchPkt  headData;
    logic     pushReq;
    logic     queueFull;
    logic     headValid;
    logic     popReq;
    logic     redirect;
    word      redirectPc;

    // ------------------------------
    // Back end
    // ------------------------------
    execPkt   execData;
    memPkt    memData;
    bypassPkt exBypass;
    bypassPkt memBypass;
    logic     exIsLoad;
    regAddr   exDest;
    wbPkt     wb;

    fetchUnit fetch (
        .clk          (clk),
        .rstN         (rstN),
        .queueFull    (queueFull),
        .redirect     (redirect),
        .redirectPc   (redirectPc),
        .instrAddress (instrAddress),
        .instr        (instr),
        .fetchOut     (fetchData),
        .push         (pushReq)
    );

    instrQueue queue (
        .clk       (clk),
        .rstN      (rstN),
        .push      (pushReq),
        .pushData  (fetchData),
        .pop       (popReq),
        .flush     (redirect),
        .head      (headData),
        .headValid (headValid),
        .full      (queueFull)
    );

    decodeStage decode (
        .clk        (clk),
        .rstN       (rstN),
        .head       (headData),
        .headValid  (headValid),
        .pop        (popReq),
        .redirect   (redirect),
        .redirectPc (redirectPc),
        .exBypass   (exBypass),
        .memBypass  (memBypass),
        .exIsLoad   (exIsLoad),
        .exDest     (exDest),
        .wb         (wb),
        .execOut    (execData)
    );

    executeStage execute (
        .clk      (clk),
        .rstN     (rstN),
        .execIn   (execData),
        .exBypass (exBypass),
        .exIsLoad (exIsLoad),
        .exDest   (exDest),
        .memOut   (memData)
    );

    memoryStage memory (
        .clk         (clk),
        .rstN        (rstN),
        .memIn       (memData),
        .dataAddress (dataAddress),
        .memRead     (memRead),
        .memWrite    (memWrite),
        .writeData   (writeData),
        .readData    (readData),
        .memBypass   (memBypass),
        .wb          (wb)
    );

endmodule

// ==== src/mipsIsaPkg.sv ====
package mipsIsaPkg;

    // ------------------------------
    // Instruction formats
    // ------------------------------
    typedef struct packed {
        logic [5:0] opcode;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } rTypeFmt;

    typedef struct packed {
        logic [5:0]  opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm16;
    } iTypeFmt;

    typedef struct packed {
        logic [5:0]  opcode;
        logic [25:0] target26;
    } jTypeFmt;

    // One 32-bit word, three views
    typedef union packed {
        rTypeFmt rType;
        iTypeFmt iType;
        jTypeFmt jType;
    } instrWord;

    // ------------------------------
    // Opcodes
    // ------------------------------
    localparam logic [5:0] opSpecial = 6'h00;
    localparam logic [5:0] opJ       = 6'h02;
    localparam logic [5:0] opBeq     = 6'h04;
    localparam logic [5:0] opBne     = 6'h05;
    localparam logic [5:0] opAddiu   = 6'h09;
    localparam logic [5:0] opOri     = 6'h0d;
    localparam logic [5:0] opLui     = 6'h0f;
    localparam logic [5:0] opLw      = 6'h23;
    localparam logic [5:0] opSw      = 6'h2b;

    // Function codes under opSpecial
    localparam logic [5:0] fnSll  = 6'h00;
    localparam logic [5:0] fnAddu = 6'h21;
    localparam logic [5:0] fnSubu = 6'h23;
    localparam logic [5:0] fnAnd  = 6'h24;
    localparam logic [5:0] fnOr   = 6'h25;
    localparam logic [5:0] fnSlt  = 6'h2a;

    typedef enum logic [3:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluSlt,
        aluSll,
        aluLui,
        aluPassB
    } aluOp;

endpackage

// ==== src/mipsPipePkg.sv ====
package mipsPipePkg;

    localparam int xlen       = 32;
    localparam int regAddrW   = 5;
    localparam int queueDepth = 4;
    localparam int queuePtrW  = $clog2(queueDepth);

    typedef logic [xlen-1:0]     word;
    typedef logic [regAddrW-1:0] regAddr;

    // ------------------------------
    // Stage-to-stage bundles
    // ------------------------------

    // Fetch to decode through the queue
    typedef struct packed {
        mipsIsaPkg::instrWord instr;
        word                  pc;
    } fetchPkt;

    // Decode to execute
    typedef struct packed {
        logic             valid;
        mipsIsaPkg::aluOp aluCtl;
        word              opA;
        word              opB;
        logic [4:0]       shamt;
        word              storeData;
        regAddr           dest;
        logic             regWrite;
        logic             memRead;
        logic             memWrite;
    } execPkt;

    // Execute to memory
    typedef struct packed {
        logic   valid;
        word    aluResult;
        word    storeData;
        regAddr dest;
        logic   regWrite;
        logic   memRead;
        logic   memWrite;
    } memPkt;

    // One forwarded result
    typedef struct packed {
        logic   valid;
        regAddr dest;
        word    data;
    } bypassPkt;

    // Register-file write port, same layout as a bypass
    typedef bypassPkt wbPkt;

endpackage

// ==== src/registerFile.sv ====
module registerFile (
    input  logic                clk,
    input  logic                rstN,
    input  mipsPipePkg::regAddr rsAddr,
    input  mipsPipePkg::regAddr rtAddr,
    output mipsPipePkg::word    rsData,
    output mipsPipePkg::word    rtData,
    input  mipsPipePkg::wbPkt   wb
);
    import mipsPipePkg::*;

    // $zero has no storage
    word regs [1:31];

    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.valid && wb.dest != '0) begin
            regs[wb.dest] <= wb.data;
        end
    end

    // Write-through so decode sees this cycle's write-back
    assign rsData = (rsAddr == '0) ? '0 :
                    (wb.valid && wb.dest == rsAddr) ? wb.data : regs[rsAddr];
    assign rtData = (rtAddr == '0) ? '0 :
                    (wb.valid && wb.dest == rtAddr) ? wb.data : regs[rtAddr];

endmodule

// ==== testbench/mipsCoreTb.sv ====
module mipsCoreTb;
    timeunit 1ns;
    timeprecision 100ps;
    import mipsPipePkg::*;

    localparam int storeTotal = 11;
    localparam int phaseLimit = 200;

    logic clk;
    logic rstN;
    word  instrAddress;
    word  instr;
    word  dataAddress;
    logic memRead;
    logic memWrite;
    word  writeData;
    word  readData;

    word imem [64];
    word dmem [64];
    int  passCount = 0;
    int  failCount = 0;

    tbClock clockGen (
        .clk  (clk),
        .rstN (rstN)
    );

    mipsCore i_dut (
        .clk          (clk),
        .rstN         (rstN),
        .instrAddress (instrAddress),
        .instr        (instr),
        .dataAddress  (dataAddress),
        .memRead      (memRead),
        .memWrite     (memWrite),
        .writeData    (writeData),
        .readData     (readData)
    );

    // ------------------------------
    // Memory models
    // ------------------------------
    assign instr    = imem[instrAddress[7:2]];
    assign readData = dmem[dataAddress[7:2]];

    function automatic word fillWord(int idx);
        return {16'hc0de, 16'(idx * 4)};
    endfunction

    always @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < 64; i++) begin
                dmem[i] <= fillWord(i);
            end
        end else if (memWrite) begin
            dmem[dataAddress[7:2]] <= writeData;
        end
    end

    function automatic word encR(logic [5:0] funct, int rd, int rs, int rt, int shamt);
        return {6'h00, 5'(rs), 5'(rt), 5'(rd), 5'(shamt), funct};
    endfunction

    function automatic word encI(logic [5:0] op, int rs, int rt, logic [15:0] imm);
        return {op, 5'(rs), 5'(rt), imm};
    endfunction

    function automatic word encJ(word target);
        return {6'h02, target[27:2]};
    endfunction

    // Hand-assembled program, word k sits at PC 4k
    initial begin
        for (int i = 0; i < 64; i++) begin
            imem[i] = '0;
        end
        imem[0]  = encI(6'h09, 0, 1, 16'd5);       // addiu r1, r0, 5
        imem[1]  = encI(6'h09, 1, 2, 16'd3);       // addiu r2, r1, 3
        imem[2]  = encI(6'h0f, 0, 3, 16'h1234);    // lui r3, 0x1234
        imem[3]  = encI(6'h0d, 3, 3, 16'h5678);    // ori r3, r3, 0x5678
        imem[4]  = encR(6'h21, 4, 2, 1, 0);        // addu r4, r2, r1
        imem[5]  = encR(6'h23, 5, 3, 2, 0);        // subu r5, r3, r2
        imem[6]  = encI(6'h2b, 0, 4, 16'd0);       // sw r4, 0(r0)
        imem[7]  = encR(6'h24, 6, 5, 3, 0);        // and r6, r5, r3
        imem[8]  = encR(6'h25, 7, 6, 1, 0);        // or r7, r6, r1
        imem[9]  = encI(6'h2b, 0, 7, 16'd4);       // sw r7, 4(r0)
        imem[10] = encI(6'h09, 0, 8, 16'hffff);    // addiu r8, r0, -1
        imem[11] = encR(6'h2a, 9, 8, 1, 0);        // slt r9, r8, r1
        imem[12] = encR(6'h00, 10, 0, 1, 4);       // sll r10, r1, 4
        imem[13] = encI(6'h2b, 0, 9, 16'd8);       // sw r9, 8(r0)
        imem[14] = encI(6'h2b, 0, 10, 16'd12);     // sw r10, 12(r0)
        imem[15] = encI(6'h2b, 0, 5, 16'd16);      // sw r5, 16(r0)
        // Load-use pair
        imem[16] = encI(6'h2b, 0, 3, 16'd24);      // sw r3, 24(r0)
        imem[17] = encI(6'h23, 0, 12, 16'd24);     // lw r12, 24(r0)
        imem[18] = encR(6'h21, 13, 12, 1, 0);      // addu r13, r12, r1
        imem[19] = encI(6'h2b, 0, 13, 16'd28);     // sw r13, 28(r0)
        // Control flow, poison stores at 0xfc
        imem[20] = encI(6'h04, 1, 1, 16'd1);       // beq r1, r1, +1 (taken)
        imem[21] = encI(6'h2b, 0, 1, 16'd252);
        imem[22] = encI(6'h2b, 0, 1, 16'd32);      // sw r1, 32(r0)
        imem[23] = encI(6'h05, 1, 1, 16'd1);       // bne r1, r1, +1 (not taken)
        imem[24] = encI(6'h2b, 0, 2, 16'd36);      // sw r2, 36(r0)
        imem[25] = encI(6'h05, 1, 2, 16'd1);       // bne r1, r2, +1 (taken)
        imem[26] = encI(6'h2b, 0, 1, 16'd252);
        imem[27] = encI(6'h2b, 0, 3, 16'd40);      // sw r3, 40(r0)
        imem[28] = encJ(32'h78);                   // j 0x78
        imem[29] = encI(6'h2b, 0, 1, 16'd252);
        imem[30] = encI(6'h2b, 0, 8, 16'd44);      // sw r8, 44(r0)
        imem[31] = encJ(32'h7c);                   // j 0x7c, parks the core
    end

    // ------------------------------
    // Phase helpers
    // ------------------------------
    task automatic waitForReset(input int limit, output bit reached);
        int cycles;
        cycles = 0;
        while (!rstN && cycles < limit) begin
            @(negedge clk);
            cycles++;
        end
        reached = rstN;
    endtask

    task automatic waitForStores(input int target, input int limit, output bit reached);
        int cycles;
        cycles = 0;
        while (i_dut.chk.storeCount < target && cycles < limit) begin
            @(negedge clk);
            cycles++;
        end
        reached = (i_dut.chk.storeCount >= target);
    endtask

    task automatic reportPhase(input string name, input bit ok, input string milestone,
                               input int errsBefore);
        if (!ok) begin
            failCount++;
            $display("FAIL %s: %s was not reached in time", name, milestone);
        end else if (i_dut.chk.assertFails != errsBefore) begin
            failCount++;
            $display("FAIL %s: %0d assertion failures", name,
                     i_dut.chk.assertFails - errsBefore);
        end else begin
            passCount++;
            $display("PASS %s", name);
        end
    endtask

    function automatic bit readBack(string name, int idx, word expected);
        if (dmem[idx] !== expected) begin
            $display("** Error at %0t ns: %s expected %h, got %h", $time, name,
                     expected, dmem[idx]);
            return 1'b0;
        end
        return 1'b1;
    endfunction

    initial begin
        bit reached;
        bit dataOk;
        int errsBefore;

        errsBefore = 0;
        waitForReset(20, reached);
        repeat (3) @(negedge clk);
        reportPhase("reset state", reached, "reset release", errsBefore);

        errsBefore = i_dut.chk.assertFails;
        waitForStores(5, phaseLimit, reached);
        reportPhase("arithmetic and forwarding", reached, "store 5", errsBefore);

        errsBefore = i_dut.chk.assertFails;
        waitForStores(7, phaseLimit, reached);
        reportPhase("load-use", reached, "store 7", errsBefore);

        errsBefore = i_dut.chk.assertFails;
        waitForStores(storeTotal, phaseLimit, reached);
        reportPhase("control flow", reached, "store 11", errsBefore);

        // Self-jump loop must stay silent
        errsBefore = i_dut.chk.assertFails;
        repeat (40) @(negedge clk);
        dataOk = readBack("dmem[0x1c]", 7, 32'h1234_567d);
        dataOk = readBack("dmem[0xfc]", 63, fillWord(63)) && dataOk;
        if (i_dut.chk.storeCount != storeTotal) begin
            $display("Store count ended at %0d instead of %0d",
                     i_dut.chk.storeCount, storeTotal);
            dataOk = 1'b0;
        end
        reportPhase("completion", dataOk, "final memory image", errsBefore);

        $display("Summary: %0d phases passed, %0d phases failed, %0d assertion failures",
                 passCount, failCount, i_dut.chk.assertFails);
        if (failCount == 0 && i_dut.chk.assertFails == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== testbench/mipsCore_chk.sv ====
module mipsCoreChk (
    input logic             clk,
    input logic             rstN,
    input mipsPipePkg::word instrAddress,
    input mipsPipePkg::word dataAddress,
    input logic             memRead,
    input logic             memWrite,
    input mipsPipePkg::word writeData
);
    timeunit 1ns;
    timeprecision 100ps;
    import mipsPipePkg::*;

    localparam int  storeTotal   = 11;
    localparam int  loadUseStore = 6;
    localparam word poisonAddr   = 32'h0000_00fc;
    localparam word loadAddr     = 32'h0000_0018;

    // ------------------------------
    // Expected stores in program order
    // ------------------------------
    localparam word expAddr [storeTotal] = '{
        32'h00, 32'h04, 32'h08, 32'h0c, 32'h10, 32'h18,
        32'h1c, 32'h20, 32'h24, 32'h28, 32'h2c
    };
    localparam word expData [storeTotal] = '{
        32'h0000_000d,  // 5 + 8
        32'h1234_5675,  // (r5 & r3) | 5
        32'h0000_0001,  // Signed -1 < 5
        32'h0000_0050,  // 5 << 4
        32'h1234_5670,  // 0x12345678 - 8
        32'h1234_5678,
        32'h1234_567d,  // Loaded word + 5
        32'h0000_0005,
        32'h0000_0008,
        32'h1234_5678,
        32'hffff_ffff
    };

    int storeCount = 0;
    int loadCount = 0;
    int assertFails = 0;

    always @(posedge clk) begin
        if (!rstN) begin
            storeCount <= 0;
        end else if (memWrite) begin
            storeCount <= storeCount + 1;
        end
    end

    always @(posedge clk) begin
        if (!rstN) begin
            loadCount <= 0;
        end else if (memRead) begin
            loadCount <= loadCount + 1;
        end
    end

    // First cycle out of reset
    resetState: assert property (@(posedge clk)
        $rose(rstN) |-> instrAddress == '0 && !memRead && !memWrite)
        else begin
            assertFails++;
            $error("state after reset release: instrAddress %h, memRead %b, memWrite %b",
                   $sampled(instrAddress), $sampled(memRead), $sampled(memWrite));
        end

    fetchAligned: assert property (@(posedge clk) disable iff (!rstN)
        instrAddress[1:0] == 2'b00)
        else begin
            assertFails++;
            $error("instrAddress %h is not word-aligned", $sampled(instrAddress));
        end

    storeInRange: assert property (@(posedge clk) disable iff (!rstN)
        memWrite |-> storeCount < storeTotal)
        else begin
            assertFails++;
            $error("more than %0d stores", storeTotal);
        end

    storeAddress: assert property (@(posedge clk) disable iff (!rstN)
        memWrite && storeCount < storeTotal |-> dataAddress == expAddr[storeCount])
        else begin
            assertFails++;
            $error("store %0d dataAddress expected %h, got %h", $sampled(storeCount),
                   expAddr[$sampled(storeCount)], $sampled(dataAddress));
        end

    storeValue: assert property (@(posedge clk) disable iff (!rstN)
        memWrite && storeCount < storeTotal |-> writeData == expData[storeCount])
        else begin
            assertFails++;
            $error("store %0d writeData expected %h, got %h", $sampled(storeCount),
                   expData[$sampled(storeCount)], $sampled(writeData));
        end

    // Skipped stores all target this word
    noPoison: assert property (@(posedge clk) disable iff (!rstN)
        memWrite |-> dataAddress != poisonAddr)
        else begin
            assertFails++;
            $error("store reached poison address %h", poisonAddr);
        end

    loadTarget: assert property (@(posedge clk) disable iff (!rstN)
        memRead |-> dataAddress == loadAddr)
        else begin
            assertFails++;
            $error("load dataAddress expected %h, got %h", loadAddr, $sampled(dataAddress));
        end

    // The dependent store follows exactly one load cycle on the port
    loadSeen: assert property (@(posedge clk) disable iff (!rstN)
        memWrite && storeCount == loadUseStore |-> loadCount == 1)
        else begin
            assertFails++;
            $error("store %0d came after %0d memRead cycles instead of 1",
                   $sampled(storeCount), $sampled(loadCount));
        end

endmodule

bind mipsCore mipsCoreChk chk (
    .clk          (clk),
    .rstN         (rstN),
    .instrAddress (instrAddress),
    .dataAddress  (dataAddress),
    .memRead      (memRead),
    .memWrite     (memWrite),
    .writeData    (writeData)
);

// ==== testbench/tbClock.sv ====
module tbClock (
    output logic clk,
    output logic rstN
);
    timeunit 1ns;
    timeprecision 100ps;

    // 20 ns period
    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Reset held for 8 cycles, released on a falling edge
    initial begin
        rstN = 1'b0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rstN = 1'b1;
    end

endmodule
